// ==== common/cdma_pkg.sv ====
`default_nettype none

package cdma_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] host_addr_t;
    typedef logic [7:0]  ram_addr_t;
    // Top bit picks the RAM, low bits index the word
    typedef logic [8:0]  mem_ptr_t;
    typedef logic [8:0]  xfer_len_t;

    typedef enum logic [1:0] {
        COPY_IDLE,
        COPY_RUN,
        COPY_DRAIN
    } copy_state_t;

    // Address map
    localparam host_addr_t CDMA_BASE   = 32'h4000_0000;
    localparam int         WINDOW_BITS = 16;

    localparam logic [1:0] REG_REGION   = 2'd0;
    localparam logic [1:0] RAM_A_REGION = 2'd1;
    localparam logic [1:0] RAM_B_REGION = 2'd2;

    // Word indices inside the register region
    localparam logic [9:0] REG_SRC    = 10'd0;
    localparam logic [9:0] REG_DST    = 10'd1;
    localparam logic [9:0] REG_LEN    = 10'd2;
    localparam logic [9:0] REG_CTRL   = 10'd3;
    localparam logic [9:0] REG_STATUS = 10'd4;

    localparam int CTRL_GO_BIT      = 0;
    localparam int CTRL_IRQ_EN_BIT  = 1;
    localparam int STATUS_BUSY_BIT  = 0;
    localparam int STATUS_DONE_BIT  = 1;
    localparam int STATUS_EMPTY_BIT = 2;

    localparam int    RAM_WORDS = 256;
    localparam word_t DEAD_WORD = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

// ==== source/periph_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_ram import cdma_pkg::*; #(
    parameter int DEPTH = RAM_WORDS
) (
    input  wire            clk,
    input  wire            host_wr_i,
    input  wire            host_rd_i,
    input  wire ram_addr_t host_addr_i,
    input  wire word_t     host_wdata_i,
    output word_t          host_rdata_o,
    input  wire            eng_wr_i,
    input  wire            eng_rd_i,
    input  wire ram_addr_t eng_rd_addr_i,
    input  wire ram_addr_t eng_wr_addr_i,
    input  wire word_t     eng_wdata_i,
    output word_t          eng_rdata_o
);

    word_t mem [DEPTH];
    word_t host_rdata_q;
    word_t eng_rdata_q;

    // Engine write takes the shared write port over the host
    always_ff @(posedge clk) begin
        if (eng_wr_i) begin
            mem[eng_wr_addr_i] <= eng_wdata_i;
        end else if (host_wr_i) begin
            mem[host_addr_i] <= host_wdata_i;
        end
        if (host_rd_i) begin
            host_rdata_q <= mem[host_addr_i];
        end
        if (eng_rd_i) begin
            eng_rdata_q <= mem[eng_rd_addr_i];
        end
    end

    assign host_rdata_o = host_rdata_q;
    assign eng_rdata_o  = eng_rdata_q;

endmodule

`default_nettype wire

// ==== source/reg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_decode import cdma_pkg::*; (
    input  wire             clk,
    input  wire             reset_i,
    input  wire             host_wr_i,
    input  wire             host_rd_i,
    input  wire host_addr_t host_addr_i,
    input  wire word_t      host_wdata_i,
    output word_t           host_rdata_o,
    output logic            host_rvalid_o,
    input  wire             busy_i,
    input  wire word_t      status_i,
    input  wire word_t      ram_a_rdata_i,
    input  wire word_t      ram_b_rdata_i,
    output logic            ram_wr_a_o,
    output logic            ram_wr_b_o,
    output logic            ram_rd_a_o,
    output logic            ram_rd_b_o,
    output ram_addr_t       ram_addr_o,
    output word_t           ram_wdata_o,
    output mem_ptr_t        src_o,
    output mem_ptr_t        dst_o,
    output xfer_len_t       len_o,
    output logic            go_o,
    output logic            irq_en_o,
    output logic            status_clear_o,
    output word_t           clear_mask_o
);

    logic [WINDOW_BITS-1:0] offset;
    logic                   hit;
    logic [1:0]             region;
    logic [9:0]             reg_idx;
    logic                   reg_wr;
    logic                   reg_rd;
    word_t                  reg_rdata;

    mem_ptr_t   src_q;
    mem_ptr_t   dst_q;
    xfer_len_t  len_q;
    logic       irq_en_q;
    logic       rvalid_q;
    logic [1:0] rd_sel_q;
    word_t      reg_rdata_q;

    // Strip the base, then split into region and word index
    assign offset  = host_addr_i[WINDOW_BITS-1:0];
    assign hit     = (host_addr_i[31:WINDOW_BITS] == CDMA_BASE[31:WINDOW_BITS])
                     && (offset[WINDOW_BITS-1:14] == '0);
    assign region  = offset[13:12];
    assign reg_idx = offset[11:2];

    assign reg_wr = host_wr_i && hit && (region == REG_REGION);
    assign reg_rd = host_rd_i && hit && (region == REG_REGION);

    assign ram_wr_a_o  = host_wr_i && hit && (region == RAM_A_REGION);
    assign ram_wr_b_o  = host_wr_i && hit && (region == RAM_B_REGION);
    assign ram_rd_a_o  = host_rd_i && hit && (region == RAM_A_REGION);
    assign ram_rd_b_o  = host_rd_i && hit && (region == RAM_B_REGION);
    assign ram_addr_o  = offset[9:2];
    assign ram_wdata_o = host_wdata_i;

    assign go_o           = reg_wr && (reg_idx == REG_CTRL) && host_wdata_i[CTRL_GO_BIT];
    assign status_clear_o = reg_wr && (reg_idx == REG_STATUS);
    assign clear_mask_o   = host_wdata_i;

    always_comb begin
        reg_rdata = '0;
        case (reg_idx)
            REG_SRC:    reg_rdata = word_t'(src_q);
            REG_DST:    reg_rdata = word_t'(dst_q);
            REG_LEN:    reg_rdata = word_t'(len_q);
            REG_CTRL:   reg_rdata[CTRL_IRQ_EN_BIT] = irq_en_q;
            REG_STATUS: reg_rdata = status_i;
            default:    reg_rdata = DEAD_WORD;
        endcase
    end

    // Transfer setup is frozen while a copy runs
    always_ff @(posedge clk) begin
        if (reset_i) begin
            src_q    <= '0;
            dst_q    <= '0;
            len_q    <= '0;
            irq_en_q <= 1'b0;
        end else if (reg_wr) begin
            case (reg_idx)
                REG_SRC:  if (!busy_i) src_q <= host_wdata_i[8:0];
                REG_DST:  if (!busy_i) dst_q <= host_wdata_i[8:0];
                REG_LEN:  if (!busy_i) len_q <= host_wdata_i[8:0];
                REG_CTRL: irq_en_q <= host_wdata_i[CTRL_IRQ_EN_BIT];
                default:  ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rvalid_q <= 1'b0;
            rd_sel_q <= 2'd3;
        end else begin
            rvalid_q <= host_rd_i;
            if (host_rd_i) begin
                rd_sel_q <= hit ? region : 2'd3;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata_q <= reg_rdata;
        end
    end

    always_comb begin
        case (rd_sel_q)
            REG_REGION:   host_rdata_o = reg_rdata_q;
            RAM_A_REGION: host_rdata_o = ram_a_rdata_i;
            RAM_B_REGION: host_rdata_o = ram_b_rdata_i;
            default:      host_rdata_o = DEAD_WORD;
        endcase
    end

    assign host_rvalid_o = rvalid_q;
    assign src_o         = src_q;
    assign dst_o         = dst_q;
    assign len_o         = len_q;
    assign irq_en_o      = irq_en_q;

endmodule

`default_nettype wire

// ==== cdma/copy_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module copy_execute import cdma_pkg::*; (
    input  wire            clk,
    input  wire            reset_i,
    input  wire            go_i,
    input  wire mem_ptr_t  src_i,
    input  wire mem_ptr_t  dst_i,
    input  wire xfer_len_t len_i,
    output logic           rd_a_o,
    output logic           rd_b_o,
    output logic           wr_a_o,
    output logic           wr_b_o,
    output ram_addr_t      rd_addr_o,
    output ram_addr_t      wr_addr_o,
    input  wire word_t     ram_a_rdata_i,
    input  wire word_t     ram_b_rdata_i,
    output word_t          wdata_o,
    output logic           busy_o,
    output logic           finish_o,
    output logic           empty_o
);

    copy_state_t state_q;
    ram_addr_t   rd_ptr_q;
    ram_addr_t   wr_ptr_q;
    xfer_len_t   rd_left_q;
    logic        src_sel_q;
    logic        dst_sel_q;
    logic        wr_pend_q;
    logic        finish_q;
    logic        empty_q;
    logic        rd_en;
    logic        accept;

    assign rd_en  = (state_q == COPY_RUN);
    assign accept = (state_q == COPY_IDLE) && go_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= COPY_IDLE;
            wr_pend_q <= 1'b0;
            finish_q  <= 1'b0;
            empty_q   <= 1'b0;
        end else begin
            // Data returns one cycle after its read
            wr_pend_q <= rd_en;
            finish_q  <= 1'b0;
            empty_q   <= 1'b0;
            case (state_q)
                COPY_IDLE: begin
                    if (go_i) begin
                        if (len_i == '0) begin
                            finish_q <= 1'b1;
                            empty_q  <= 1'b1;
                        end else begin
                            state_q <= COPY_RUN;
                        end
                    end
                end
                COPY_RUN: begin
                    if (rd_left_q == xfer_len_t'(1)) begin
                        state_q <= COPY_DRAIN;
                    end
                end
                COPY_DRAIN: begin
                    state_q  <= COPY_IDLE;
                    finish_q <= 1'b1;
                end
                default: state_q <= COPY_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_ptr_q  <= src_i[7:0];
            wr_ptr_q  <= dst_i[7:0];
            src_sel_q <= src_i[8];
            dst_sel_q <= dst_i[8];
            rd_left_q <= len_i;
        end else begin
            if (rd_en) begin
                rd_ptr_q  <= rd_ptr_q + 1'b1;
                rd_left_q <= rd_left_q - 1'b1;
            end
            if (wr_pend_q) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
        end
    end

    assign rd_a_o    = rd_en && !src_sel_q;
    assign rd_b_o    = rd_en && src_sel_q;
    assign wr_a_o    = wr_pend_q && !dst_sel_q;
    assign wr_b_o    = wr_pend_q && dst_sel_q;
    assign rd_addr_o = rd_ptr_q;
    assign wr_addr_o = wr_ptr_q;
    assign wdata_o   = src_sel_q ? ram_b_rdata_i : ram_a_rdata_i;
    assign busy_o    = (state_q != COPY_IDLE);
    assign finish_o  = finish_q;
    assign empty_o   = empty_q;

endmodule

`default_nettype wire

// ==== cdma/status_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_result import cdma_pkg::*; (
    input  wire        clk,
    input  wire        reset_i,
    input  wire        finish_i,
    input  wire        empty_i,
    input  wire        busy_i,
    input  wire        irq_en_i,
    input  wire        status_clear_i,
    input  wire word_t clear_mask_i,
    output word_t      status_o,
    output logic       irq_o
);

    logic done_q;
    logic empty_q;
    logic irq_q;
    logic done_d;
    logic empty_d;

    // A finish in the same cycle as a clear wins
    always_comb begin
        done_d  = done_q && !(status_clear_i && clear_mask_i[STATUS_DONE_BIT]);
        empty_d = empty_q && !(status_clear_i && clear_mask_i[STATUS_EMPTY_BIT]);
        if (finish_i) begin
            done_d  = 1'b1;
            empty_d = empty_d || empty_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            done_q  <= 1'b0;
            empty_q <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            done_q  <= done_d;
            empty_q <= empty_d;
            irq_q   <= done_d && irq_en_i;
        end
    end

    always_comb begin
        status_o                   = '0;
        status_o[STATUS_BUSY_BIT]  = busy_i;
        status_o[STATUS_DONE_BIT]  = done_q;
        status_o[STATUS_EMPTY_BIT] = empty_q;
    end

    assign irq_o = irq_q;

endmodule

`default_nettype wire

// ==== source/cdma_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdma_soc import cdma_pkg::*; (
    input  wire             clk,
    input  wire             reset_i,
    input  wire             host_wr_i,
    input  wire             host_rd_i,
    input  wire host_addr_t host_addr_i,
    input  wire word_t      host_wdata_i,
    output word_t           host_rdata_o,
    output logic            host_rvalid_o,
    output logic            irq_o
);

    // Host side of the RAMs
    logic      ram_wr_a;
    logic      ram_wr_b;
    logic      ram_rd_a;
    logic      ram_rd_b;
    ram_addr_t ram_addr;
    word_t     ram_wdata;
    word_t     ram_a_host_rdata;
    word_t     ram_b_host_rdata;

    // Engine side
    logic      eng_rd_a;
    logic      eng_rd_b;
    logic      eng_wr_a;
    logic      eng_wr_b;
    ram_addr_t eng_rd_addr;
    ram_addr_t eng_wr_addr;
    word_t     eng_wdata;
    word_t     ram_a_eng_rdata;
    word_t     ram_b_eng_rdata;

    mem_ptr_t  src;
    mem_ptr_t  dst;
    xfer_len_t len;
    logic      go;
    logic      irq_en;
    logic      busy;
    logic      finish;
    logic      empty;
    logic      status_clear;
    word_t     clear_mask;
    word_t     status;

    reg_decode u_reg_decode (
        .clk            (clk),
        .reset_i        (reset_i),
        .host_wr_i      (host_wr_i),
        .host_rd_i      (host_rd_i),
        .host_addr_i    (host_addr_i),
        .host_wdata_i   (host_wdata_i),
        .host_rdata_o   (host_rdata_o),
        .host_rvalid_o  (host_rvalid_o),
        .busy_i         (busy),
        .status_i       (status),
        .ram_a_rdata_i  (ram_a_host_rdata),
        .ram_b_rdata_i  (ram_b_host_rdata),
        .ram_wr_a_o     (ram_wr_a),
        .ram_wr_b_o     (ram_wr_b),
        .ram_rd_a_o     (ram_rd_a),
        .ram_rd_b_o     (ram_rd_b),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata),
        .src_o          (src),
        .dst_o          (dst),
        .len_o          (len),
        .go_o           (go),
        .irq_en_o       (irq_en),
        .status_clear_o (status_clear),
        .clear_mask_o   (clear_mask)
    );

    copy_execute u_copy_execute (
        .clk           (clk),
        .reset_i       (reset_i),
        .go_i          (go),
        .src_i         (src),
        .dst_i         (dst),
        .len_i         (len),
        .rd_a_o        (eng_rd_a),
        .rd_b_o        (eng_rd_b),
        .wr_a_o        (eng_wr_a),
        .wr_b_o        (eng_wr_b),
        .rd_addr_o     (eng_rd_addr),
        .wr_addr_o     (eng_wr_addr),
        .ram_a_rdata_i (ram_a_eng_rdata),
        .ram_b_rdata_i (ram_b_eng_rdata),
        .wdata_o       (eng_wdata),
        .busy_o        (busy),
        .finish_o      (finish),
        .empty_o       (empty)
    );

    status_result u_status_result (
        .clk            (clk),
        .reset_i        (reset_i),
        .finish_i       (finish),
        .empty_i        (empty),
        .busy_i         (busy),
        .irq_en_i       (irq_en),
        .status_clear_i (status_clear),
        .clear_mask_i   (clear_mask),
        .status_o       (status),
        .irq_o          (irq_o)
    );

    periph_ram u_ram_a (
        .clk           (clk),
        .host_wr_i     (ram_wr_a),
        .host_rd_i     (ram_rd_a),
        .host_addr_i   (ram_addr),
        .host_wdata_i  (ram_wdata),
        .host_rdata_o  (ram_a_host_rdata),
        .eng_wr_i      (eng_wr_a),
        .eng_rd_i      (eng_rd_a),
        .eng_rd_addr_i (eng_rd_addr),
        .eng_wr_addr_i (eng_wr_addr),
        .eng_wdata_i   (eng_wdata),
        .eng_rdata_o   (ram_a_eng_rdata)
    );

    periph_ram u_ram_b (
        .clk           (clk),
        .host_wr_i     (ram_wr_b),
        .host_rd_i     (ram_rd_b),
        .host_addr_i   (ram_addr),
        .host_wdata_i  (ram_wdata),
        .host_rdata_o  (ram_b_host_rdata),
        .eng_wr_i      (eng_wr_b),
        .eng_rd_i      (eng_rd_b),
        .eng_rd_addr_i (eng_rd_addr),
        .eng_wr_addr_i (eng_wr_addr),
        .eng_wdata_i   (eng_wdata),
        .eng_rdata_o   (ram_b_eng_rdata)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o
);

    // 8 ns period
    initial clk_o = 1'b0;

    always #4 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== testbench/cdma_soc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdma_soc_checker import cdma_pkg::*; (
    input wire        clk,
    input wire        reset_i,
    input wire        rd_i,
    input wire        rvalid_i,
    input wire        irq_i,
    input wire word_t status_i
);

    read_gets_response: assert property (@(posedge clk) disable iff (reset_i)
        rd_i |=> rvalid_i)
        else $error("read strobe had no response one cycle later");

    response_needs_read: assert property (@(posedge clk) disable iff (reset_i)
        rvalid_i |-> $past(rd_i))
        else $error("read response without a read strobe one cycle before");

    // Low through reset and the first cycle after it
    irq_low_in_reset: assert property (@(posedge clk) reset_i |=> !irq_i)
        else $error("irq high right after a reset cycle");

    irq_low_after_reset: assert property (@(posedge clk) $past(reset_i) |=> !irq_i)
        else $error("irq high one cycle after reset");

    irq_needs_done: assert property (@(posedge clk) disable iff (reset_i)
        irq_i |-> status_i[STATUS_DONE_BIT])
        else $error("irq high while the done flag is clear");

endmodule

bind cdma_soc cdma_soc_checker u_cdma_soc_checker (
    .clk      (clk),
    .reset_i  (reset_i),
    .rd_i     (host_rd_i),
    .rvalid_i (host_rvalid_o),
    .irq_i    (irq_o),
    .status_i (status)
);

`default_nettype wire

// ==== testbench/cdma_soc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdma_soc_tb import cdma_pkg::*; ();

    logic       clk;
    logic       reset_i;
    logic       host_wr_i;
    logic       host_rd_i;
    host_addr_t host_addr_i;
    word_t      host_wdata_i;
    word_t      host_rdata_o;
    logic       host_rvalid_o;
    logic       irq_o;

    // Reference model of both RAMs and the registers
    word_t     ref_ram_a [RAM_WORDS];
    word_t     ref_ram_b [RAM_WORDS];
    mem_ptr_t  ref_src;
    mem_ptr_t  ref_dst;
    xfer_len_t ref_len;
    logic      ref_irq_en;
    logic      ref_done;
    logic      ref_empty;

    word_t       expected_q [$];
    int unsigned watchdog_cycles = 0;

    tb_clock u_tb_clock (
        .clk_o (clk)
    );

    cdma_soc u_cdma_soc (
        .clk           (clk),
        .reset_i       (reset_i),
        .host_wr_i     (host_wr_i),
        .host_rd_i     (host_rd_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .host_rdata_o  (host_rdata_o),
        .host_rvalid_o (host_rvalid_o),
        .irq_o         (irq_o)
    );

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s expected 0x%08h got 0x%08h", name, expected, got);
            $display("Simulation failed");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s expected 0x%0h got 0x%0h", name, expected, got);
            $display("Simulation failed");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    function automatic host_addr_t reg_addr(input int idx);
        return CDMA_BASE | host_addr_t'(idx << 2);
    endfunction

    function automatic host_addr_t ram_addr(input logic [1:0] region, input int idx);
        return CDMA_BASE | (host_addr_t'(region) << 12) | host_addr_t'(idx << 2);
    endfunction

    function automatic word_t status_bits(input logic done, input logic empty);
        word_t bits;
        bits = '0;
        bits[STATUS_DONE_BIT]  = done;
        bits[STATUS_EMPTY_BIT] = empty;
        return bits;
    endfunction

    function automatic logic addr_hit(input host_addr_t addr);
        return (addr[31:WINDOW_BITS] == CDMA_BASE[31:WINDOW_BITS]) && (addr[15:14] == 2'b00);
    endfunction

    // Expected read data from the address map and the model state
    function automatic word_t expected_read(input host_addr_t addr);
        word_t data;
        data = DEAD_WORD;
        if (addr_hit(addr)) begin
            case (addr[13:12])
                REG_REGION: begin
                    case (addr[11:2])
                        REG_SRC:    data = word_t'(ref_src);
                        REG_DST:    data = word_t'(ref_dst);
                        REG_LEN:    data = word_t'(ref_len);
                        REG_CTRL:   data = word_t'(ref_irq_en) << CTRL_IRQ_EN_BIT;
                        REG_STATUS: data = status_bits(ref_done, ref_empty);
                        default:    data = DEAD_WORD;
                    endcase
                end
                RAM_A_REGION: data = ref_ram_a[addr[9:2]];
                RAM_B_REGION: data = ref_ram_b[addr[9:2]];
                default:      data = DEAD_WORD;
            endcase
        end
        return data;
    endfunction

    function automatic void model_write(input host_addr_t addr, input word_t data);
        if (addr_hit(addr)) begin
            case (addr[13:12])
                REG_REGION: begin
                    case (addr[11:2])
                        REG_SRC:  ref_src = data[8:0];
                        REG_DST:  ref_dst = data[8:0];
                        REG_LEN:  ref_len = data[8:0];
                        REG_CTRL: ref_irq_en = data[CTRL_IRQ_EN_BIT];
                        REG_STATUS: begin
                            ref_done  = ref_done && !data[STATUS_DONE_BIT];
                            ref_empty = ref_empty && !data[STATUS_EMPTY_BIT];
                        end
                        default: ;
                    endcase
                end
                RAM_A_REGION: ref_ram_a[addr[9:2]] = data;
                RAM_B_REGION: ref_ram_b[addr[9:2]] = data;
                default: ;
            endcase
        end
    endfunction

    function automatic void model_copy();
        ram_addr_t s_idx;
        ram_addr_t d_idx;
        word_t     w;
        s_idx = ref_src[7:0];
        d_idx = ref_dst[7:0];
        for (int i = 0; i < int'(ref_len); i++) begin
            w = ref_src[8] ? ref_ram_b[s_idx] : ref_ram_a[s_idx];
            if (ref_dst[8]) begin
                ref_ram_b[d_idx] = w;
            end else begin
                ref_ram_a[d_idx] = w;
            end
            s_idx = s_idx + 8'd1;
            d_idx = d_idx + 8'd1;
        end
        ref_done  = 1'b1;
        ref_empty = (ref_len == '0);
    endfunction

    task automatic host_write(input host_addr_t addr, input word_t data);
        @(posedge clk);
        host_wr_i    <= 1'b1;
        host_rd_i    <= 1'b0;
        host_addr_i  <= addr;
        host_wdata_i <= data;
        model_write(addr, data);
    endtask

    task automatic host_read(input host_addr_t addr);
        @(posedge clk);
        host_wr_i   <= 1'b0;
        host_rd_i   <= 1'b1;
        host_addr_i <= addr;
        expected_q.push_back(expected_read(addr));
    endtask

    task automatic host_idle();
        @(posedge clk);
        host_wr_i <= 1'b0;
        host_rd_i <= 1'b0;
    endtask

    // Responses trail their reads by one cycle, so a few cycles is plenty
    task automatic wait_responses();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < 4) begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("%0d read responses never arrived", expected_q.size());
            $display("Simulation failed");
            $fatal(1, "Missing read responses");
        end
    endtask

    task automatic compare_rams();
        for (int i = 0; i < RAM_WORDS; i++) begin
            host_read(ram_addr(RAM_A_REGION, i));
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            host_read(ram_addr(RAM_B_REGION, i));
        end
        host_idle();
        wait_responses();
    endtask

    task automatic run_copy(input mem_ptr_t src, input mem_ptr_t dst, input xfer_len_t len,
                            input logic irq_en);
        word_t ctrl;
        ctrl = '0;
        ctrl[CTRL_GO_BIT]     = 1'b1;
        ctrl[CTRL_IRQ_EN_BIT] = irq_en;
        // Clear leftover flags so the interrupt edge is fresh
        host_write(reg_addr(int'(REG_STATUS)), status_bits(1'b1, 1'b1));
        host_write(reg_addr(int'(REG_SRC)), word_t'(src));
        host_write(reg_addr(int'(REG_DST)), word_t'(dst));
        host_write(reg_addr(int'(REG_LEN)), word_t'(len));
        check_flag("irq_o", irq_o, 1'b0);
        host_write(reg_addr(int'(REG_CTRL)), ctrl);
        host_idle();
        model_copy();
        if (irq_en) begin
            while (irq_o !== 1'b1) begin
                @(posedge clk);
            end
        end else begin
            repeat (int'(len) + 8) begin
                @(posedge clk);
                check_flag("irq_o", irq_o, 1'b0);
            end
        end
        host_read(reg_addr(int'(REG_STATUS)));
        host_idle();
        wait_responses();
    endtask

    // Every response is checked against the oldest outstanding read
    always @(posedge clk) begin
        word_t expected;
        if (!reset_i && host_rvalid_o === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("A read response arrived with no read outstanding");
                $display("Simulation failed");
                $fatal(1, "Unexpected read response");
            end else begin
                expected = expected_q.pop_front();
                check_word("host_rdata_o", host_rdata_o, expected);
            end
        end
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
        $display("Simulation failed");
        $fatal(1, "Timeout");
    end

    initial begin
        xfer_len_t len_ab;
        xfer_len_t len_ba;
        xfer_len_t len_same;
        xfer_len_t len_noirq;
        int        idx;
        int        s_idx;
        int        d_idx;

        reset_i      = 1'b1;
        host_wr_i    = 1'b0;
        host_rd_i    = 1'b0;
        host_addr_i  = '0;
        host_wdata_i = '0;
        ref_src      = '0;
        ref_dst      = '0;
        ref_len      = '0;
        ref_irq_en   = 1'b0;
        ref_done     = 1'b0;
        ref_empty    = 1'b0;

        void'($urandom(32'ha9856cf0));
        len_ab    = xfer_len_t'(1 + $urandom % 64);
        len_ba    = xfer_len_t'(1 + $urandom % 64);
        len_same  = xfer_len_t'(1 + $urandom % 64);
        len_noirq = xfer_len_t'(1 + $urandom % 64);
        watchdog_cycles = 40 * (int'(len_ab) + int'(len_ba) + int'(len_same)
                          + int'(len_noirq)) + 4000;

        repeat (16) @(posedge clk);
        reset_i <= 1'b0;

        // Registers come out of reset as zero
        for (int i = 0; i <= int'(REG_STATUS); i++) begin
            host_read(reg_addr(i));
        end
        host_write(reg_addr(int'(REG_SRC)), word_t'($urandom));
        host_write(reg_addr(int'(REG_DST)), word_t'($urandom));
        host_write(reg_addr(int'(REG_LEN)), word_t'($urandom));
        host_write(reg_addr(int'(REG_CTRL)), word_t'(1) << CTRL_IRQ_EN_BIT);
        for (int i = 0; i <= int'(REG_STATUS); i++) begin
            host_read(reg_addr(i));
        end
        host_write(reg_addr(int'(REG_CTRL)), '0);
        host_read(reg_addr(int'(REG_CTRL)));
        // Outside the base, so SRC must not move
        host_write(32'h4001_0000, word_t'($urandom));
        host_read(reg_addr(int'(REG_SRC)));
        host_read(reg_addr(5));
        host_read(reg_addr(1023));
        host_read(CDMA_BASE | 32'h0000_3000);
        host_read(32'h5000_0000);
        host_read(32'h4001_0004);
        host_idle();
        wait_responses();

        // RAM windows
        for (int i = 0; i < RAM_WORDS; i++) begin
            host_write(ram_addr(RAM_A_REGION, i), word_t'($urandom));
            host_write(ram_addr(RAM_B_REGION, i), word_t'($urandom));
        end
        compare_rams();
        for (int i = 0; i < 8; i++) begin
            idx = int'($urandom % RAM_WORDS);
            host_write(ram_addr(RAM_A_REGION, idx), word_t'($urandom));
            host_read(ram_addr(RAM_A_REGION, idx));
            host_read(ram_addr(RAM_B_REGION, idx));
            idx = int'($urandom % RAM_WORDS);
            host_write(ram_addr(RAM_B_REGION, idx), word_t'($urandom));
            host_read(ram_addr(RAM_B_REGION, idx));
            host_read(ram_addr(RAM_A_REGION, idx));
        end
        host_idle();
        wait_responses();

        // A to B
        s_idx = int'($urandom % (257 - int'(len_ab)));
        d_idx = int'($urandom % (257 - int'(len_ab)));
        run_copy({1'b0, ram_addr_t'(s_idx)}, {1'b1, ram_addr_t'(d_idx)}, len_ab, 1'b1);
        compare_rams();

        // B to A
        s_idx = int'($urandom % (257 - int'(len_ba)));
        d_idx = int'($urandom % (257 - int'(len_ba)));
        run_copy({1'b1, ram_addr_t'(s_idx)}, {1'b0, ram_addr_t'(d_idx)}, len_ba, 1'b1);
        compare_rams();

        // Inside RAM A from the lower half to the upper half
        s_idx = int'($urandom % 64);
        d_idx = 128 + int'($urandom % 64);
        run_copy({1'b0, ram_addr_t'(s_idx)}, {1'b0, ram_addr_t'(d_idx)}, len_same, 1'b1);
        compare_rams();

        // Zero-length copy and flag clearing
        run_copy({1'b0, 8'd0}, {1'b1, 8'd0}, '0, 1'b1);
        host_write(reg_addr(int'(REG_STATUS)), status_bits(1'b1, 1'b1));
        host_idle();
        @(posedge clk);
        check_flag("irq_o", irq_o, 1'b0);
        host_read(reg_addr(int'(REG_STATUS)));
        host_idle();
        wait_responses();

        // Interrupt disabled
        s_idx = int'($urandom % (257 - int'(len_noirq)));
        d_idx = int'($urandom % (257 - int'(len_noirq)));
        run_copy({1'b1, ram_addr_t'(s_idx)}, {1'b0, ram_addr_t'(d_idx)}, len_noirq, 1'b0);
        check_flag("irq_o", irq_o, 1'b0);
        host_read(reg_addr(int'(REG_CTRL)));
        host_idle();
        compare_rams();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
common/cdma_pkg.sv
source/periph_ram.sv
source/reg_decode.sv
cdma/copy_execute.sv
cdma/status_result.sv
source/cdma_soc.sv
testbench/tb_clock.sv
testbench/cdma_soc_checker.sv
testbench/cdma_soc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CDMA testbench with Verilator.
# Exit status is the simulator's, nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cdma_soc_tb \
    --Mdir obj_dir -o cdma_soc_sim \
    -f list.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/cdma_soc_sim
run_status=$?
if [ "$run_status" -ne 0 ]; then
    echo "Simulation run exited with status $run_status"
    exit "$run_status"
fi

exit 0
